/* hw/robPkg.sv */
package robPkg;

  // machine sizes
  localparam int archCount = 32;
  localparam int physCount = 48;
  localparam int robDepth = 16;

  localparam int archIdxBits = $clog2(archCount);
  localparam int physIdxBits = $clog2(physCount);
  localparam int robIdxBits = $clog2(robDepth);

  // tags outside the architectural map, i.e. the free list ring size
  localparam int freeCount = physCount - archCount;
  localparam int freeIdxBits = $clog2(freeCount);
  // one extra bit so a full ring can be told apart from an empty one
  localparam int freeCountBits = freeIdxBits + 1;

  // one instruction entering rename
  typedef struct packed {
    logic                   enable;
    logic [archIdxBits-1:0] destIdx;
    logic                   halt;
  } dispatchReq;

  // execution finished, reported by buffer slot
  typedef struct packed {
    logic                  enable;
    logic [robIdxBits-1:0] robIdx;
  } completeReq;

  // mispredicted branch and its buffer slot
  typedef struct packed {
    logic                  enable;
    logic [robIdxBits-1:0] robIdx;
  } rollbackReq;

  typedef struct packed {
    logic                   valid;
    logic                   complete;
    logic                   halt;
    logic [archIdxBits-1:0] destIdx;
    logic [physIdxBits-1:0] newTag;
    logic [physIdxBits-1:0] oldTag;
  } robEntry;

  // head entry leaving the machine
  typedef struct packed {
    logic                   enable;
    logic [archIdxBits-1:0] destIdx;
    logic [physIdxBits-1:0] newTag;
    logic [physIdxBits-1:0] oldTag;
  } retireInfo;

endpackage

/* hw/mapTable.sv */
`timescale 1ns/1ps

module mapTable
  import robPkg::*;
(
  input  logic                   clock,
  input  logic                   reset,
  input  logic                   dispatchFire,
  input  logic [archIdxBits-1:0] destIdx,
  input  logic [physIdxBits-1:0] newTag,
  output logic [physIdxBits-1:0] oldTag,
  input  retireInfo              retire,
  input  logic                   recover
);

  // front end view, includes unretired renames
  logic [physIdxBits-1:0] specMap [archCount];
  // committed view, only changed at retire
  logic [physIdxBits-1:0] archMap [archCount];

  // previous mapping goes into the buffer entry with the new tag
  assign oldTag = specMap[destIdx];

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int r = 0; r < archCount; r++) begin
        specMap[r] <= physIdxBits'(r);
      end
    end else if (recover) begin
      // discard all speculative renames in one step
      specMap <= archMap;
    end else if (dispatchFire) begin
      specMap[destIdx] <= newTag;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int r = 0; r < archCount; r++) begin
        archMap[r] <= physIdxBits'(r);
      end
    end else if (retire.enable) begin
      archMap[retire.destIdx] <= retire.newTag;
    end
  end

  // the buffer is empty during the recover cycle, so nothing retires there
  noRetireOnRecover: assert property (
    @(posedge clock) disable iff (reset)
    recover |-> !retire.enable
  );

endmodule

/* hw/freeList.sv */
`timescale 1ns/1ps

module freeList
  import robPkg::*;
(
  input  logic                   clock,
  input  logic                   reset,
  input  logic                   dispatchFire,
  output logic [physIdxBits-1:0] newTag,
  input  retireInfo              retire,
  input  logic                   recover
);

  logic [physIdxBits-1:0] tags [freeCount];
  logic [freeIdxBits-1:0] head;
  logic [freeIdxBits-1:0] tail;
  logic [freeCountBits-1:0] count;
  logic empty;

  assign empty = (count == '0);

  // empty ring with a retire in the same cycle hands the freed tag straight on
  assign newTag = empty ? retire.oldTag : tags[head];

  always_ff @(posedge clock) begin
    if (reset) begin
      head <= '0;
      tail <= '0;
      count <= freeCountBits'(freeCount);
      for (int i = 0; i < freeCount; i++) begin
        tags[i] <= physIdxBits'(archCount + i);
      end
    end else begin
      if (retire.enable) begin
        tags[tail] <= retire.oldTag;
        tail <= tail + 1'b1;
      end
      if (recover) begin
        // ring holds 16 slots, so tail minus 16 lands on tail itself
        head <= tail;
        count <= freeCountBits'(freeCount);
      end else begin
        if (dispatchFire) begin
          head <= head + 1'b1;
        end
        case ({dispatchFire, retire.enable})
          2'b10: count <= count - 1'b1;
          2'b01: count <= count + 1'b1;
          default: count <= count;
        endcase
      end
    end
  end

  // sizing keeps free tags plus in-flight tags at 16, so this never trips
  noPopWhenEmpty: assert property (
    @(posedge clock) disable iff (reset)
    dispatchFire |-> !empty || retire.enable
  );

endmodule

/* hw/reorderBuffer.sv */
`timescale 1ns/1ps

module reorderBuffer
  import robPkg::*;
(
  input  logic                   clock,
  input  logic                   reset,
  input  logic                   dispatchFire,
  input  dispatchReq             dispatch,
  input  logic [physIdxBits-1:0] newTag,
  input  logic [physIdxBits-1:0] oldTag,
  input  completeReq             complete,
  input  rollbackReq             rollback,
  output logic                   dispatchReady,
  output logic [robIdxBits-1:0]  robTailIdx,
  output retireInfo              retire,
  output logic                   haltOut,
  output logic                   recover
);

  robEntry entries [robDepth];
  robEntry entriesNext [robDepth];
  robEntry headEntry;

  logic [robIdxBits-1:0] head;
  logic [robIdxBits-1:0] headNext;
  logic [robIdxBits-1:0] tail;
  logic [robIdxBits-1:0] tailNext;

  // recovery FSM state
  logic                  recovering;
  logic                  recoveringNext;
  logic                  recoverNext;
  logic [robIdxBits-1:0] branchIdx;
  logic [robIdxBits-1:0] activeBranch;

  logic mispredict;
  logic pending;
  logic branchRetiring;
  logic wrapped;

  assign headEntry = entries[head];

  // oldest entry leaves once it is complete
  always_comb begin
    retire.enable  = headEntry.valid && headEntry.complete;
    retire.destIdx = headEntry.destIdx;
    retire.newTag  = headEntry.newTag;
    retire.oldTag  = headEntry.oldTag;
  end

  assign haltOut = retire.enable && headEntry.halt;
  assign robTailIdx = tail;

  // a full buffer still accepts when the head frees its slot this cycle
  assign dispatchReady = !recovering && !recover && !rollback.enable &&
                         (!entries[tail].valid || retire.enable);

  // rollback to an empty slot is stale, drop it
  assign mispredict = rollback.enable && entries[rollback.robIdx].valid;

  assign pending = mispredict || recovering;
  assign activeBranch = mispredict ? rollback.robIdx : branchIdx;
  assign branchRetiring = retire.enable && (head == activeBranch);

  // recovery ends at the edge where the branch itself retires
  assign recoveringNext = pending && !branchRetiring;
  assign recoverNext = pending && branchRetiring;

  // branch at or past the tail means the younger run wraps through slot 0
  assign wrapped = rollback.robIdx >= tail;

  always_comb begin
    entriesNext = entries;
    headNext = head;
    tailNext = tail;

    if (complete.enable) begin
      entriesNext[complete.robIdx].complete = 1'b1;
    end

    if (retire.enable) begin
      entriesNext[head].valid = 1'b0;
      headNext = head + 1'b1;
    end

    // written after retire so a full buffer can reuse the head slot
    if (dispatchFire) begin
      entriesNext[tail].valid = 1'b1;
      entriesNext[tail].complete = 1'b0;
      entriesNext[tail].halt = dispatch.halt;
      entriesNext[tail].destIdx = dispatch.destIdx;
      entriesNext[tail].newTag = newTag;
      entriesNext[tail].oldTag = oldTag;
      tailNext = tail + 1'b1;
    end

    // squash everything younger than the branch
    if (mispredict) begin
      for (int i = 0; i < robDepth; i++) begin
        if (wrapped) begin
          if (i > rollback.robIdx || i < tail) begin
            entriesNext[i].valid = 1'b0;
          end
        end else begin
          if (i > rollback.robIdx && i < tail) begin
            entriesNext[i].valid = 1'b0;
          end
        end
      end
      tailNext = rollback.robIdx + 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      head <= '0;
      tail <= '0;
      recovering <= 1'b0;
      recover <= 1'b0;
      branchIdx <= '0;
      for (int i = 0; i < robDepth; i++) begin
        entries[i].valid <= 1'b0;
        entries[i].complete <= 1'b0;
      end
    end else begin
      entries <= entriesNext;
      head <= headNext;
      tail <= tailNext;
      recovering <= recoveringNext;
      recover <= recoverNext;
      if (mispredict) begin
        branchIdx <= rollback.robIdx;
      end
    end
  end

  // completion must come from an instruction still in flight
  completeTargetsValid: assert property (
    @(posedge clock) disable iff (reset)
    complete.enable |-> entries[complete.robIdx].valid
  );

  // the top level has to honour dispatchReady through the whole recovery
  noDispatchWhileRecovering: assert property (
    @(posedge clock) disable iff (reset)
    dispatchFire |-> !recovering && !recover
  );

  recoverIsPulse: assert property (
    @(posedge clock) disable iff (reset)
    recover |=> !recover
  );

endmodule

/* hw/renameCore.sv */
`timescale 1ns/1ps

module renameCore
  import robPkg::*;
(
  input  logic                   clock,
  input  logic                   reset,
  input  dispatchReq             dispatch,
  input  completeReq             complete,
  input  rollbackReq             rollback,
  output logic                   dispatchReady,
  output logic [robIdxBits-1:0]  robTailIdx,
  output logic [physIdxBits-1:0] newTag,
  output retireInfo              retire,
  output logic                   haltOut
);

  logic dispatchFire;
  logic recover;
  logic [physIdxBits-1:0] oldTag;

  // rename, allocate and pop all happen on this one strobe
  assign dispatchFire = dispatch.enable && dispatchReady;

  mapTable mapTableInst (
    .clock        (clock),
    .reset        (reset),
    .dispatchFire (dispatchFire),
    .destIdx      (dispatch.destIdx),
    .newTag       (newTag),
    .oldTag       (oldTag),
    .retire       (retire),
    .recover      (recover)
  );

  freeList freeListInst (
    .clock        (clock),
    .reset        (reset),
    .dispatchFire (dispatchFire),
    .newTag       (newTag),
    .retire       (retire),
    .recover      (recover)
  );

  // buffer pairs the new tag with the mapping it replaces
  reorderBuffer robInst (
    .clock         (clock),
    .reset         (reset),
    .dispatchFire  (dispatchFire),
    .dispatch      (dispatch),
    .newTag        (newTag),
    .oldTag        (oldTag),
    .complete      (complete),
    .rollback      (rollback),
    .dispatchReady (dispatchReady),
    .robTailIdx    (robTailIdx),
    .retire        (retire),
    .haltOut       (haltOut),
    .recover       (recover)
  );

endmodule

/* bench/clockGen.sv */
`timescale 1ns/1ps

module clockGen (
  output logic clock,
  output logic reset
);

  // 10 ns period
  initial begin
    clock = 1'b0;
    forever #5 clock = ~clock;
  end

  // held over three rising edges, dropped just after the third
  initial begin
    reset = 1'b1;
    repeat (3) @(posedge clock);
    #1 reset = 1'b0;
  end

endmodule

/* bench/renameCoreTb.sv */
`timescale 1ns/1ps

module renameCoreTb
  import robPkg::*;
();

  localparam int fieldCount = 15;
  localparam int maxVectors = 64;
  localparam int resetTimeout = 20;
  localparam int drainTimeout = 40;

  logic clock;
  logic reset;
  dispatchReq dispatch;
  completeReq complete;
  rollbackReq rollback;
  logic dispatchReady;
  logic [robIdxBits-1:0] robTailIdx;
  logic [physIdxBits-1:0] newTag;
  retireInfo retire;
  logic haltOut;

  // one byte per column, fieldCount columns per cycle
  logic [7:0] vectorMem [fieldCount*maxVectors];
  int vectorCount;
  int mismatchCount;
  int otherCount;

  clockGen clockGenInst (
    .clock (clock),
    .reset (reset)
  );

  renameCore i_renameCore (
    .clock         (clock),
    .reset         (reset),
    .dispatch      (dispatch),
    .complete      (complete),
    .rollback      (rollback),
    .dispatchReady (dispatchReady),
    .robTailIdx    (robTailIdx),
    .newTag        (newTag),
    .retire        (retire),
    .haltOut       (haltOut)
  );

  task automatic checkValue(input string what, input int vecIdx,
                            input logic [31:0] actual, input logic [31:0] expected);
    if (actual !== expected) begin
      mismatchCount++;
      $display("MISMATCH at %0t: vector %0d %s is %0h, expected %0h",
               $time, vecIdx, what, actual, expected);
    end
  endtask

  task automatic idleInputs();
    dispatch = '0;
    complete = '0;
    rollback = '0;
  endtask

  task automatic applyVector(input int v);
    int base;
    base = v * fieldCount;
    dispatch.enable = vectorMem[base][0];
    dispatch.destIdx = vectorMem[base+1][archIdxBits-1:0];
    dispatch.halt = vectorMem[base+2][0];
    complete.enable = vectorMem[base+3][0];
    complete.robIdx = vectorMem[base+4][robIdxBits-1:0];
    rollback.enable = vectorMem[base+5][0];
    rollback.robIdx = vectorMem[base+6][robIdxBits-1:0];
  endtask

  task automatic checkVector(input int v);
    int base;
    logic expReady;
    logic expRetire;
    base = v * fieldCount;
    expReady = vectorMem[base+7][0];
    expRetire = vectorMem[base+10][0];
    checkValue("dispatchReady", v, 32'(dispatchReady), 32'(expReady));
    checkValue("robTailIdx", v, 32'(robTailIdx), 32'(vectorMem[base+8]));
    // the offered tag only means something when dispatch can go
    if (expReady) begin
      checkValue("newTag", v, 32'(newTag), 32'(vectorMem[base+9]));
    end
    checkValue("retire.enable", v, 32'(retire.enable), 32'(expRetire));
    if (expRetire) begin
      checkValue("retire.destIdx", v, 32'(retire.destIdx), 32'(vectorMem[base+11]));
      checkValue("retire.newTag", v, 32'(retire.newTag), 32'(vectorMem[base+12]));
      checkValue("retire.oldTag", v, 32'(retire.oldTag), 32'(vectorMem[base+13]));
    end
    checkValue("haltOut", v, 32'(haltOut), 32'(vectorMem[base+14]));
  endtask

  initial begin
    int waitCycles;
    mismatchCount = 0;
    otherCount = 0;
    vectorCount = 0;
    idleInputs();

    // unused rows stay at ff and mark the end of the data
    for (int i = 0; i < fieldCount * maxVectors; i++) begin
      vectorMem[i] = 8'hff;
    end
    $readmemh("bench/renameVectors.txt", vectorMem);
    while (vectorCount < maxVectors && vectorMem[vectorCount * fieldCount] != 8'hff) begin
      vectorCount++;
    end
    if (vectorCount == 0) begin
      $display("ERROR: no vectors were read from bench/renameVectors.txt");
      otherCount++;
    end

    // first look at reset only after a clock edge
    waitCycles = 0;
    do begin
      @(posedge clock);
      waitCycles++;
    end while (reset && waitCycles < resetTimeout);

    if (reset) begin
      $display("ERROR: reset was still high after %0d cycles", resetTimeout);
      otherCount++;
    end else begin
      // drive just after the edge, sample just before the next one
      for (int v = 0; v < vectorCount; v++) begin
        @(posedge clock);
        #1;
        applyVector(v);
        #8;
        checkVector(v);
      end

      @(posedge clock);
      #1;
      idleInputs();
      #8;
      waitCycles = 0;
      while (!(dispatchReady && !retire.enable) && waitCycles < drainTimeout) begin
        @(posedge clock);
        #9;
        waitCycles++;
      end
      if (!(dispatchReady && !retire.enable)) begin
        $display("ERROR: the DUT did not go idle within %0d cycles after the last vector",
                 drainTimeout);
        otherCount++;
      end
    end

    $display("%0d vectors, %0d mismatches, %0d other errors",
             vectorCount, mismatchCount, otherCount);
    if (mismatchCount == 0 && otherCount == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

/* verilog.f */
hw/robPkg.sv
hw/mapTable.sv
hw/freeList.sv
hw/reorderBuffer.sv
hw/renameCore.sv
bench/clockGen.sv
bench/renameCoreTb.sv

/* run.sh */
#!/bin/sh
# compile the bench with Verilator, run it, and look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal -f verilog.f --top-module renameCoreTb -o simRename
buildStatus=$?
if [ $buildStatus -ne 0 ]; then
  echo "verilator build failed with status $buildStatus"
  exit 1
fi

simOutput=$(./obj_dir/simRename)
simStatus=$?
printf '%s\n' "$simOutput"
if [ $simStatus -ne 0 ]; then
  echo "simulation exited with status $simStatus"
  exit 1
fi

if printf '%s\n' "$simOutput" | grep -qx "ALL TESTS PASSED"; then
  exit 0
else
  echo "pass line not found in simulation output"
  exit 1
fi

/* bench/renameVectors.txt */
// one cycle per line in hex: dispEn dispDest dispHalt cmpEn cmpIdx rbEn rbIdx, then expected
// ready tailIdx newTag retEn retDest retNewTag retOldTag haltOut
// rename r3, r5, r3 right after reset
01 03 00 00 00 00 00  01 00 20 00 00 00 00 00
01 05 00 00 00 00 00  01 01 21 00 00 00 00 00
01 03 00 01 01 00 00  01 02 22 00 00 00 00 00
// slot 0 completes after slot 1, retire stays in order
00 00 00 01 00 00 00  01 03 23 00 00 00 00 00
00 00 00 01 02 00 00  01 03 23 01 03 20 03 00
00 00 00 00 00 00 00  01 03 23 01 05 21 05 00
00 00 00 00 00 00 00  01 03 23 01 03 22 20 00
// fill all 16 slots, slot 4 holds a halt
01 0a 00 00 00 00 00  01 03 23 00 00 00 00 00
01 0b 01 00 00 00 00  01 04 24 00 00 00 00 00
01 0c 00 00 00 00 00  01 05 25 00 00 00 00 00
01 0d 00 00 00 00 00  01 06 26 00 00 00 00 00
01 0e 00 00 00 00 00  01 07 27 00 00 00 00 00
01 0f 00 00 00 00 00  01 08 28 00 00 00 00 00
01 10 00 00 00 00 00  01 09 29 00 00 00 00 00
01 11 00 00 00 00 00  01 0a 2a 00 00 00 00 00
01 12 00 00 00 00 00  01 0b 2b 00 00 00 00 00
01 13 00 00 00 00 00  01 0c 2c 00 00 00 00 00
01 14 00 00 00 00 00  01 0d 2d 00 00 00 00 00
01 15 00 00 00 00 00  01 0e 2e 00 00 00 00 00
01 16 00 00 00 00 00  01 0f 2f 00 00 00 00 00
// tag 47 is gone, freed tags 3, 5 and 32 come next
01 17 00 01 04 00 00  01 00 03 00 00 00 00 00
01 18 00 01 05 00 00  01 01 05 00 00 00 00 00
01 19 00 00 00 00 00  01 02 20 00 00 00 00 00
// full, then the head retires and the slot is reused at once
01 1a 00 01 03 00 00  00 03 0a 00 00 00 00 00
01 1a 00 00 00 00 00  01 03 0a 01 0a 23 0a 00
// rollback to slot 5 in the cycle the halt retires
00 00 00 00 00 01 05  00 04 0b 01 0b 24 0b 01
00 00 00 00 00 00 00  00 06 0b 01 0c 25 0c 00
00 00 00 00 00 00 00  00 06 0b 00 00 00 00 00
// after recover, old tags come from the committed map
01 0d 00 00 00 00 00  01 06 26 00 00 00 00 00
01 1a 00 01 06 00 00  01 07 27 00 00 00 00 00
00 00 00 01 07 00 00  01 08 28 01 0d 26 0d 00
00 00 00 00 00 00 00  01 08 28 01 1a 27 1a 00
// rollback to an empty slot does nothing
00 00 00 00 00 01 03  00 08 28 00 00 00 00 00
00 00 00 00 00 00 00  01 08 28 00 00 00 00 00
